//--- Makefile
# Verilator flow for the bypass unit testbench

VERILATOR ?= verilator
TOP       ?= bypassUnitTb
FILELIST  ?= bypassUnit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Finished with no errors

SOURCES := $(shell grep -E '\.(sv|v)$$' $(FILELIST)) include/bypassTbModel.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bypassUnit.f
+incdir+include
hdl/bypassPkg.sv
hdl/bypassTracker.sv
hdl/operandSelector.sv
hdl/operandMux.sv
hdl/bypassUnit.sv
testbench/bypassUnitTb.sv

//--- hdl/bypassPkg.sv
// Bypass network shared types
// Widths, vector types and stage names

package bypassPkg;

    // Physical register number
    localparam int pRegNumWidth = 6;
    typedef logic [pRegNumWidth-1:0] pRegNum;

    // Operand and result words
    localparam int dataWidth = 32;
    typedef logic [dataWidth-1:0] dataWord;

    // Upper bound on lanes in either group
    localparam int maxLanes = 4;
    typedef logic [$clog2(maxLanes)-1:0] laneIndex;

    // Producer stage of a forwarded value
    // Zero encoding doubles as the idle value of a select
    typedef enum logic [1:0] {
        stageIntEx = 2'd0,
        stageIntWb = 2'd1,
        stageMemMa = 2'd2,
        stageMemWb = 2'd3
    } bypassStage;

endpackage

//--- hdl/bypassTracker.sv
// Destination tag pipelines

`timescale 1ns/1ps

module bypassTracker
    import bypassPkg::*;
#(
    parameter int intLanes = 2,
    parameter int memLanes = 1
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   stall,
    input  logic   clear,
    input  pRegNum intDstReg   [intLanes],
    input  logic   intWriteReg [intLanes],
    input  pRegNum memDstReg   [memLanes],
    input  logic   memWriteReg [memLanes],
    output pRegNum intExReg    [intLanes],
    output pRegNum intWbReg    [intLanes],
    output pRegNum memMaReg    [memLanes],
    output pRegNum memWbReg    [memLanes],
    output logic   intExWrite  [intLanes],
    output logic   intWbWrite  [intLanes],
    output logic   memMaWrite  [memLanes],
    output logic   memWbWrite  [memLanes]
);

    // Integer lanes: EX, WB
    localparam int intDepth = 2;
    localparam int intEx = 0;
    localparam int intWb = 1;

    // Load lanes: EX, MT, MA, WB
    localparam int memDepth = 4;
    localparam int memMa = 2;
    localparam int memWb = 3;

    pRegNum intTag  [intDepth][intLanes];
    logic   intFlag [intDepth][intLanes];
    pRegNum memTag  [memDepth][memLanes];
    logic   memFlag [memDepth][memLanes];
    logic   anyWrite;

    // Write flags, the only state that must be cleared
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            for (int s = 0; s < intDepth; s++) begin
                for (int i = 0; i < intLanes; i++) begin
                    intFlag[s][i] <= 1'b0;
                end
            end
            for (int s = 0; s < memDepth; s++) begin
                for (int i = 0; i < memLanes; i++) begin
                    memFlag[s][i] <= 1'b0;
                end
            end
        end else if (!stall) begin
            for (int i = 0; i < intLanes; i++) begin
                intFlag[0][i] <= intWriteReg[i];
                for (int s = 1; s < intDepth; s++) begin
                    intFlag[s][i] <= intFlag[s-1][i];
                end
            end
            for (int i = 0; i < memLanes; i++) begin
                memFlag[0][i] <= memWriteReg[i];
                for (int s = 1; s < memDepth; s++) begin
                    memFlag[s][i] <= memFlag[s-1][i];
                end
            end
        end
    end

    // Tags just follow their flags down the chain
    always_ff @(posedge clk) begin
        if (!stall) begin
            for (int i = 0; i < intLanes; i++) begin
                intTag[0][i] <= intDstReg[i];
                for (int s = 1; s < intDepth; s++) begin
                    intTag[s][i] <= intTag[s-1][i];
                end
            end
            for (int i = 0; i < memLanes; i++) begin
                memTag[0][i] <= memDstReg[i];
                for (int s = 1; s < memDepth; s++) begin
                    memTag[s][i] <= memTag[s-1][i];
                end
            end
        end
    end

    // Producer view for the selectors
    always_comb begin
        for (int i = 0; i < intLanes; i++) begin
            intExReg[i]   = intTag[intEx][i];
            intExWrite[i] = intFlag[intEx][i];
            intWbReg[i]   = intTag[intWb][i];
            intWbWrite[i] = intFlag[intWb][i];
        end
        for (int i = 0; i < memLanes; i++) begin
            memMaReg[i]   = memTag[memMa][i];
            memMaWrite[i] = memFlag[memMa][i];
            memWbReg[i]   = memTag[memWb][i];
            memWbWrite[i] = memFlag[memWb][i];
        end
    end

    // Includes the hidden load EX and MT records
    always_comb begin
        anyWrite = 1'b0;
        for (int s = 0; s < intDepth; s++) begin
            for (int i = 0; i < intLanes; i++) begin
                anyWrite = anyWrite | intFlag[s][i];
            end
        end
        for (int s = 0; s < memDepth; s++) begin
            for (int i = 0; i < memLanes; i++) begin
                anyWrite = anyWrite | memFlag[s][i];
            end
        end
    end

    clearFlushesAll: assert property (@(posedge clk) clear |=> !anyWrite)
        else $error("write flag still set one cycle after clear");

endmodule

//--- hdl/bypassUnit.sv
// Operand bypass unit
// Tag tracker, per-port selectors and data mux

`timescale 1ns/1ps

module bypassUnit
    import bypassPkg::*;
#(
    parameter  int intLanes = 2,
    parameter  int memLanes = 1,
    localparam int numPorts = 2 * (intLanes + memLanes)
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    stall,
    input  logic    clear,
    input  pRegNum  intDstReg   [intLanes],
    input  logic    intWriteReg [intLanes],
    input  pRegNum  memDstReg   [memLanes],
    input  logic    memWriteReg [memLanes],
    input  pRegNum  srcReg      [numPorts],
    input  logic    readReg     [numPorts],
    input  dataWord rfData      [numPorts],
    input  dataWord intExResult [intLanes],
    input  dataWord intWbResult [intLanes],
    input  dataWord memMaResult [memLanes],
    input  dataWord memWbResult [memLanes],
    output dataWord operand     [numPorts],
    output logic    forwarded   [numPorts]
);

    // Producer records
    pRegNum intExReg   [intLanes];
    pRegNum intWbReg   [intLanes];
    pRegNum memMaReg   [memLanes];
    pRegNum memWbReg   [memLanes];
    logic   intExWrite [intLanes];
    logic   intWbWrite [intLanes];
    logic   memMaWrite [memLanes];
    logic   memWbWrite [memLanes];

    // One select per read port
    logic       selHit   [numPorts];
    bypassStage selStage [numPorts];
    laneIndex   selLane  [numPorts];

    bypassTracker #(
        .intLanes(intLanes),
        .memLanes(memLanes)
    ) u_tracker (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .clear      (clear),
        .intDstReg  (intDstReg),
        .intWriteReg(intWriteReg),
        .memDstReg  (memDstReg),
        .memWriteReg(memWriteReg),
        .intExReg   (intExReg),
        .intWbReg   (intWbReg),
        .memMaReg   (memMaReg),
        .memWbReg   (memWbReg),
        .intExWrite (intExWrite),
        .intWbWrite (intWbWrite),
        .memMaWrite (memMaWrite),
        .memWbWrite (memWbWrite)
    );

    // Ports 0 .. 2*intLanes-1 are integer A/B, the rest belong to loads
    for (genvar k = 0; k < numPorts; k++) begin : selPort
        operandSelector #(
            .intLanes(intLanes),
            .memLanes(memLanes)
        ) u_selector (
            .srcReg    (srcReg[k]),
            .readReg   (readReg[k]),
            .intExReg  (intExReg),
            .intWbReg  (intWbReg),
            .memMaReg  (memMaReg),
            .memWbReg  (memWbReg),
            .intExWrite(intExWrite),
            .intWbWrite(intWbWrite),
            .memMaWrite(memMaWrite),
            .memWbWrite(memWbWrite),
            .hit       (selHit[k]),
            .stage     (selStage[k]),
            .lane      (selLane[k])
        );
    end

    operandMux #(
        .intLanes(intLanes),
        .memLanes(memLanes),
        .numPorts(numPorts)
    ) u_mux (
        .hit        (selHit),
        .stage      (selStage),
        .lane       (selLane),
        .rfData     (rfData),
        .intExResult(intExResult),
        .intWbResult(intWbResult),
        .memMaResult(memMaResult),
        .memWbResult(memWbResult),
        .operand    (operand),
        .forwarded  (forwarded)
    );

endmodule

//--- hdl/operandMux.sv
// Operand data selection for all read ports

`timescale 1ns/1ps

module operandMux
    import bypassPkg::*;
#(
    parameter int intLanes = 2,
    parameter int memLanes = 1,
    parameter int numPorts = 2 * (intLanes + memLanes)
) (
    input  logic       hit         [numPorts],
    input  bypassStage stage       [numPorts],
    input  laneIndex   lane        [numPorts],
    input  dataWord    rfData      [numPorts],
    input  dataWord    intExResult [intLanes],
    input  dataWord    intWbResult [intLanes],
    input  dataWord    memMaResult [memLanes],
    input  dataWord    memWbResult [memLanes],
    output dataWord    operand     [numPorts],
    output logic       forwarded   [numPorts]
);

    // Value on the bus named by stage and lane
    dataWord fwdData [numPorts];

    always_comb begin
        for (int p = 0; p < numPorts; p++) begin
            fwdData[p] = '0;
            case (stage[p])
                stageIntEx, stageIntWb: begin
                    for (int l = 0; l < intLanes; l++) begin
                        if (lane[p] == laneIndex'(l)) begin
                            fwdData[p] = (stage[p] == stageIntEx) ?
                                intExResult[l] : intWbResult[l];
                        end
                    end
                end
                default: begin
                    for (int l = 0; l < memLanes; l++) begin
                        if (lane[p] == laneIndex'(l)) begin
                            fwdData[p] = (stage[p] == stageMemMa) ?
                                memMaResult[l] : memWbResult[l];
                        end
                    end
                end
            endcase

            // Selector must only name lanes that exist
            if (hit[p]) begin
                if (stage[p] == stageIntEx || stage[p] == stageIntWb) begin
                    assert (int'(lane[p]) < intLanes)
                        else $error("port %0d hit on missing int lane %0d", p, lane[p]);
                end else begin
                    assert (int'(lane[p]) < memLanes)
                        else $error("port %0d hit on missing load lane %0d", p, lane[p]);
                end
            end
        end
    end

    // Register file value unless a producer matched
    always_comb begin
        for (int p = 0; p < numPorts; p++) begin
            operand[p]   = hit[p] ? fwdData[p] : rfData[p];
            forwarded[p] = hit[p];
        end
    end

endmodule

//--- hdl/operandSelector.sv
// Bypass select for one read port

`timescale 1ns/1ps

module operandSelector
    import bypassPkg::*;
#(
    parameter int intLanes = 2,
    parameter int memLanes = 1
) (
    input  pRegNum     srcReg,
    input  logic       readReg,
    input  pRegNum     intExReg   [intLanes],
    input  pRegNum     intWbReg   [intLanes],
    input  pRegNum     memMaReg   [memLanes],
    input  pRegNum     memWbReg   [memLanes],
    input  logic       intExWrite [intLanes],
    input  logic       intWbWrite [intLanes],
    input  logic       memMaWrite [memLanes],
    input  logic       memWbWrite [memLanes],
    output logic       hit,
    output bypassStage stage,
    output laneIndex   lane
);

    // Per-producer tag matches
    logic intExMatch [intLanes];
    logic intWbMatch [intLanes];
    logic memMaMatch [memLanes];
    logic memWbMatch [memLanes];

    always_comb begin
        for (int i = 0; i < intLanes; i++) begin
            intExMatch[i] = readReg && intExWrite[i] && (intExReg[i] == srcReg);
            intWbMatch[i] = readReg && intWbWrite[i] && (intWbReg[i] == srcReg);
        end
        for (int i = 0; i < memLanes; i++) begin
            memMaMatch[i] = readReg && memMaWrite[i] && (memMaReg[i] == srcReg);
            memWbMatch[i] = readReg && memWbWrite[i] && (memWbReg[i] == srcReg);
        end
    end

    // First match wins
    // Integer lanes before loads, lower lane first, younger stage first
    always_comb begin
        hit   = 1'b0;
        stage = stageIntEx;
        lane  = '0;
        for (int i = 0; i < intLanes; i++) begin
            if (!hit && intExMatch[i]) begin
                hit   = 1'b1;
                stage = stageIntEx;
                lane  = laneIndex'(i);
            end
            if (!hit && intWbMatch[i]) begin
                hit   = 1'b1;
                stage = stageIntWb;
                lane  = laneIndex'(i);
            end
        end
        for (int i = 0; i < memLanes; i++) begin
            if (!hit && memMaMatch[i]) begin
                hit   = 1'b1;
                stage = stageMemMa;
                lane  = laneIndex'(i);
            end
            if (!hit && memWbMatch[i]) begin
                hit   = 1'b1;
                stage = stageMemWb;
                lane  = laneIndex'(i);
            end
        end
    end

endmodule

//--- include/bypassTbModel.svh
// Bypass reference model
// Tag history and expected operands

`ifndef BYPASS_TB_MODEL_SVH
`define BYPASS_TB_MODEL_SVH

localparam int mdlIntLanes = 2;
localparam int mdlMemLanes = 1;
localparam int mdlNumPorts = 2 * (mdlIntLanes + mdlMemLanes);

// Index 0 is the stage right after RR
pRegNum mdlIntTag  [2][mdlIntLanes] = '{default: '0};
logic   mdlIntFlag [2][mdlIntLanes] = '{default: 1'b0};
pRegNum mdlMemTag  [4][mdlMemLanes] = '{default: '0};
logic   mdlMemFlag [4][mdlMemLanes] = '{default: 1'b0};

// Advance the model by one rising edge
task automatic modelStep(
    input logic   rst,
    input logic   clr,
    input logic   stl,
    input pRegNum intDst [mdlIntLanes],
    input logic   intWr  [mdlIntLanes],
    input pRegNum memDst [mdlMemLanes],
    input logic   memWr  [mdlMemLanes]
);
    for (int i = 0; i < mdlIntLanes; i++) begin
        if (!stl) begin
            mdlIntTag[1][i] = mdlIntTag[0][i];
            mdlIntTag[0][i] = intDst[i];
            mdlIntFlag[1][i] = mdlIntFlag[0][i];
            mdlIntFlag[0][i] = intWr[i];
        end
        if (rst || clr) begin
            mdlIntFlag[0][i] = 1'b0;
            mdlIntFlag[1][i] = 1'b0;
        end
    end
    for (int i = 0; i < mdlMemLanes; i++) begin
        for (int s = 3; s >= 0; s--) begin
            if (!stl) begin
                mdlMemTag[s][i]  = (s == 0) ? memDst[i] : mdlMemTag[s-1][i];
                mdlMemFlag[s][i] = (s == 0) ? memWr[i] : mdlMemFlag[s-1][i];
            end
            if (rst || clr) begin
                mdlMemFlag[s][i] = 1'b0;
            end
        end
    end
endtask

// Walks the producers from lowest to highest priority, so the last hit stands
function automatic void modelExpect(
    input  pRegNum  src,
    input  logic    rd,
    input  dataWord rf,
    input  dataWord intEx [mdlIntLanes],
    input  dataWord intWb [mdlIntLanes],
    input  dataWord memMa [mdlMemLanes],
    input  dataWord memWb [mdlMemLanes],
    output dataWord value,
    output logic    fwd
);
    value = rf;
    fwd   = 1'b0;
    if (rd) begin
        for (int i = mdlMemLanes - 1; i >= 0; i--) begin
            if (mdlMemFlag[3][i] && mdlMemTag[3][i] == src) begin
                value = memWb[i];
                fwd   = 1'b1;
            end
            if (mdlMemFlag[2][i] && mdlMemTag[2][i] == src) begin
                value = memMa[i];
                fwd   = 1'b1;
            end
        end
        for (int i = mdlIntLanes - 1; i >= 0; i--) begin
            if (mdlIntFlag[1][i] && mdlIntTag[1][i] == src) begin
                value = intWb[i];
                fwd   = 1'b1;
            end
            if (mdlIntFlag[0][i] && mdlIntTag[0][i] == src) begin
                value = intEx[i];
                fwd   = 1'b1;
            end
        end
    end
endfunction

`endif

//--- testbench/bypassUnitTb.sv
// Bypass unit testbench

`timescale 1ns/1ps

module bypassUnitTb
    import bypassPkg::*;
;

    `include "bypassTbModel.svh"

    localparam int resetTimeout = 20;
    localparam int randomCycles = 3000;

    logic    clk = 1'b0;
    logic    reset;
    logic    stall;
    logic    clear;
    pRegNum  intDstReg   [mdlIntLanes];
    logic    intWriteReg [mdlIntLanes];
    pRegNum  memDstReg   [mdlMemLanes];
    logic    memWriteReg [mdlMemLanes];
    pRegNum  srcReg      [mdlNumPorts];
    logic    readReg     [mdlNumPorts];
    dataWord rfData      [mdlNumPorts];
    dataWord intExResult [mdlIntLanes];
    dataWord intWbResult [mdlIntLanes];
    dataWord memMaResult [mdlMemLanes];
    dataWord memWbResult [mdlMemLanes];
    dataWord operand     [mdlNumPorts];
    logic    forwarded   [mdlNumPorts];

    logic        checkEnable = 1'b0;
    logic [31:0] rngState = 32'd81746;

    bypassUnit u_bypassUnit (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .clear      (clear),
        .intDstReg  (intDstReg),
        .intWriteReg(intWriteReg),
        .memDstReg  (memDstReg),
        .memWriteReg(memWriteReg),
        .srcReg     (srcReg),
        .readReg    (readReg),
        .rfData     (rfData),
        .intExResult(intExResult),
        .intWbResult(intWbResult),
        .memMaResult(memMaResult),
        .memWbResult(memWbResult),
        .operand    (operand),
        .forwarded  (forwarded)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rngState = x;
        return x;
    endfunction

    // Top byte encodes the source
    // Stage code and lane for a result bus, F and port for RF data
    function automatic dataWord tagWord(input logic [3:0] code, input int idx);
        logic [31:0] r;
        r = nextRandom();
        return {code, 4'(idx), r[23:0]};
    endfunction

    task automatic checkValue(input dataWord actual, input dataWord expected,
                              input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s got %h expected %h",
                     $time, what, actual, expected);
            $display("Finished with errors");
            $fatal(1, "stopped at first wrong value");
        end
    endtask

    task automatic refreshData();
        for (int p = 0; p < mdlNumPorts; p++) begin
            rfData[p] = tagWord(4'hF, p);
        end
        for (int i = 0; i < mdlIntLanes; i++) begin
            intExResult[i] = tagWord(4'h1, i);
            intWbResult[i] = tagWord(4'h2, i);
        end
        for (int i = 0; i < mdlMemLanes; i++) begin
            memMaResult[i] = tagWord(4'h3, i);
            memWbResult[i] = tagWord(4'h4, i);
        end
    endtask

    task automatic quietWrites();
        stall = 1'b0;
        clear = 1'b0;
        for (int i = 0; i < mdlIntLanes; i++) begin
            intDstReg[i]   = '0;
            intWriteReg[i] = 1'b0;
        end
        for (int i = 0; i < mdlMemLanes; i++) begin
            memDstReg[i]   = '0;
            memWriteReg[i] = 1'b0;
        end
    endtask

    // Even ports read a and odd ports read b
    task automatic readPair(input pRegNum a, input pRegNum b);
        for (int p = 0; p < mdlNumPorts; p++) begin
            srcReg[p]  = (p % 2 == 0) ? a : b;
            readReg[p] = 1'b1;
        end
    endtask

    task automatic issueAll(input pRegNum dst);
        for (int i = 0; i < mdlIntLanes; i++) begin
            intDstReg[i]   = dst;
            intWriteReg[i] = 1'b1;
        end
        for (int i = 0; i < mdlMemLanes; i++) begin
            memDstReg[i]   = dst;
            memWriteReg[i] = 1'b1;
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
        refreshData();
    endtask

    // Small register range keeps matches frequent
    task automatic driveRandom();
        logic [31:0] r;
        r = nextRandom();
        stall = (r[2:0] == 3'd0);
        clear = (r[7:3] == 5'd0);
        for (int i = 0; i < mdlIntLanes; i++) begin
            r = nextRandom();
            intDstReg[i]   = pRegNum'(r[2:0]);
            intWriteReg[i] = (r[4:3] != 2'd0);
        end
        for (int i = 0; i < mdlMemLanes; i++) begin
            r = nextRandom();
            memDstReg[i]   = pRegNum'(r[2:0]);
            memWriteReg[i] = (r[4:3] != 2'd0);
        end
        for (int p = 0; p < mdlNumPorts; p++) begin
            r = nextRandom();
            srcReg[p]  = pRegNum'(r[2:0]);
            readReg[p] = (r[6:4] != 3'd0);
        end
    endtask

    always @(posedge clk) begin
        modelStep(reset, clear, stall, intDstReg, intWriteReg, memDstReg, memWriteReg);
    end

    // Compare shortly before each rising edge
    always @(negedge clk) begin
        dataWord expValue;
        logic    expFwd;
        #40;
        if (checkEnable) begin
            for (int p = 0; p < mdlNumPorts; p++) begin
                modelExpect(srcReg[p], readReg[p], rfData[p], intExResult, intWbResult,
                            memMaResult, memWbResult, expValue, expFwd);
                checkValue(operand[p], expValue, $sformatf("operand port %0d", p));
                checkValue(32'(forwarded[p]), 32'(expFwd),
                           $sformatf("forwarded port %0d", p));
            end
        end
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
    end

    initial begin
        int waitCount;
        quietWrites();
        refreshData();
        readPair(6'd1, 6'd2);
        waitCount = 0;
        while (reset !== 1'b0 && waitCount < resetTimeout) begin
            @(posedge clk);
            #2;
            waitCount++;
        end
        if (reset !== 1'b0) begin
            $display("timeout waiting for reset release");
            $display("Finished with errors");
            $fatal(1, "reset never released");
        end
        checkEnable = 1'b1;

        // Empty pipeline reads the register file
        repeat (4) begin
            nextCycle();
            driveRandom();
            quietWrites();
        end

        // One integer and one load producer walking down their stages
        nextCycle();
        intDstReg[1]   = 6'd5;
        intWriteReg[1] = 1'b1;
        memDstReg[0]   = 6'd9;
        memWriteReg[0] = 1'b1;
        readPair(6'd5, 6'd9);
        repeat (6) begin
            nextCycle();
            quietWrites();
        end

        // Several matching producers and one port not reading
        nextCycle();
        issueAll(6'd7);
        readPair(6'd7, 6'd7);
        readReg[1] = 1'b0;
        nextCycle();
        quietWrites();
        intDstReg[0]   = 6'd7;
        intWriteReg[0] = 1'b1;
        intDstReg[1]   = 6'd7;
        repeat (5) begin
            nextCycle();
            quietWrites();
        end

        // Stall holds the records in place
        nextCycle();
        intDstReg[0]   = 6'd12;
        intWriteReg[0] = 1'b1;
        memDstReg[0]   = 6'd13;
        memWriteReg[0] = 1'b1;
        readPair(6'd12, 6'd13);
        repeat (2) begin
            nextCycle();
            quietWrites();
        end
        repeat (4) begin
            nextCycle();
            stall = 1'b1;
        end
        repeat (5) begin
            nextCycle();
            quietWrites();
        end

        // Clear drops everything in flight
        nextCycle();
        issueAll(6'd3);
        readPair(6'd3, 6'd3);
        nextCycle();
        issueAll(6'd3);
        nextCycle();
        quietWrites();
        clear = 1'b1;
        repeat (5) begin
            nextCycle();
            quietWrites();
        end

        repeat (randomCycles) begin
            nextCycle();
            driveRandom();
        end

        repeat (2) @(posedge clk);
        $display("Finished with no errors");
        $finish;
    end

endmodule
